// File: include/shelter_queue_settings.svh
// Shelter queue sizes
`ifndef SHELTER_QUEUE_SETTINGS_SVH
`define SHELTER_QUEUE_SETTINGS_SVH

// Request field widths
`define ZONE_W 8
`define PRIO_W 2

// Waiting-time counter, wraps at the top
`define WAIT_W 8

// Queue depth, fixed by the two-level arbiter tree
`define SLOT_COUNT 4
`define INDEX_W 2

`endif

// File: rtl/shelter_queue_pkg.sv
// Shelter queue types
`include "shelter_queue_settings.svh"

package shelter_queue_pkg;

    // ------------------------------------------------------------------------
    // One queued request, as held in a slot and passed through the arbiters
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [`ZONE_W-1:0] zone;
        logic [`PRIO_W-1:0] prio;
        logic [`WAIT_W-1:0] wait_time;
        // Sticky aging flag
        logic               boost;
        logic               valid;
    } request_t;

    // All slots side by side, slot 0 in the low bits
    typedef request_t [`SLOT_COUNT-1:0] slot_array_t;

endpackage

// File: rtl/request_slot.sv
// Queue request slot
`timescale 1ns/1ps
`include "shelter_queue_settings.svh"

module request_slot (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       write,
    input  logic                       clear,
    input  logic [`ZONE_W-1:0]         new_zone,
    input  logic [`PRIO_W-1:0]         new_prio,
    input  logic [`WAIT_W-1:0]         threshold,
    output shelter_queue_pkg::request_t entry
);

    logic boost_due;

    // Aging check on the registered wait, so boost lags the wait by a cycle
    assign boost_due = entry.valid && (entry.wait_time >= threshold);

    // ------------------------------------------------------------------------
    // Slot register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            entry <= '0;
        end else if (clear) begin
            // Clear beats a write in the same cycle
            entry <= '0;
        end else if (write) begin
            entry.zone      <= new_zone;
            entry.prio      <= new_prio;
            entry.wait_time <= '0;
            entry.boost     <= 1'b0;
            entry.valid     <= 1'b1;
        end else if (entry.valid) begin
            entry.wait_time <= entry.wait_time + 1'b1;
            entry.boost     <= entry.boost | boost_due;
        end
    end

    // Boost only ever lives on an occupied slot
    a_boost_needs_valid : assert property (
        @(posedge clk) disable iff (reset)
        entry.boost |-> entry.valid
    );

    // Once set, boost holds until the slot is emptied
    a_boost_sticky : assert property (
        @(posedge clk) disable iff (reset)
        entry.boost && !clear |=> entry.boost
    );

endmodule

// File: rtl/pair_arbiter.sv
// Two-way request arbiter
`timescale 1ns/1ps
`include "shelter_queue_settings.svh"

module pair_arbiter (
    input  shelter_queue_pkg::request_t a,
    input  shelter_queue_pkg::request_t b,
    output shelter_queue_pkg::request_t winner,
    output logic                        pick_a
);

    logic boost_win;
    logic boost_tie;
    logic prio_win;
    logic prio_tie;
    logic wait_win;

    // ------------------------------------------------------------------------
    // Field comparisons, each from the point of view of a
    // ------------------------------------------------------------------------
    assign boost_win = a.boost && !b.boost;
    assign boost_tie = (a.boost == b.boost);

    assign prio_win = (a.prio > b.prio);
    assign prio_tie = (a.prio == b.prio);

    // Equal waits go to a, which keeps the lower slot index ahead
    assign wait_win = (a.wait_time >= b.wait_time);

    // ------------------------------------------------------------------------
    // Ranking: valid, then boost, then priority, then wait
    // ------------------------------------------------------------------------
    always_comb begin
        if (!a.valid) begin
            pick_a = 1'b0;
        end else if (!b.valid) begin
            pick_a = 1'b1;
        end else if (boost_win) begin
            pick_a = 1'b1;
        end else if (!boost_tie) begin
            pick_a = 1'b0;
        end else if (prio_win) begin
            pick_a = 1'b1;
        end else if (!prio_tie) begin
            pick_a = 1'b0;
        end else begin
            pick_a = wait_win;
        end
    end

    // Empty pair falls through to b, which is empty too
    assign winner = pick_a ? a : b;

endmodule

// File: rtl/selector_tree.sv
// Four-slot selector tree
`timescale 1ns/1ps
`include "shelter_queue_settings.svh"

module selector_tree (
    input  shelter_queue_pkg::slot_array_t entries,
    output shelter_queue_pkg::request_t    selected,
    output logic [`INDEX_W-1:0]            selected_index
);

    shelter_queue_pkg::request_t winner_01;
    shelter_queue_pkg::request_t winner_23;
    logic                        pick_0;
    logic                        pick_2;
    logic                        pick_01;

    // First level, slots 0/1 and slots 2/3
    pair_arbiter arb_01 (
        .a      (entries[0]),
        .b      (entries[1]),
        .winner (winner_01),
        .pick_a (pick_0)
    );

    pair_arbiter arb_23 (
        .a      (entries[2]),
        .b      (entries[3]),
        .winner (winner_23),
        .pick_a (pick_2)
    );

    // Final stage
    pair_arbiter arb_final (
        .a      (winner_01),
        .b      (winner_23),
        .winner (selected),
        .pick_a (pick_01)
    );

    // ------------------------------------------------------------------------
    // Slot index from the three choice bits
    // ------------------------------------------------------------------------
    always_comb begin
        if (pick_01) begin
            selected_index = {1'b0, !pick_0};
        end else begin
            selected_index = {1'b1, !pick_2};
        end
    end

    // Index must point back at the slot that was presented
    a_index_matches : assert final (
        !selected.valid || entries[selected_index].valid
    );

endmodule

// File: rtl/queue_storage.sv
// Queue slot storage
`timescale 1ns/1ps
`include "shelter_queue_settings.svh"

module queue_storage (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           insert,
    input  logic [`ZONE_W-1:0]             new_zone,
    input  logic [`PRIO_W-1:0]             new_prio,
    input  logic [`WAIT_W-1:0]             threshold,
    input  logic                           serve,
    input  logic [`INDEX_W-1:0]            selected_index,
    input  logic                           cancel_en,
    input  logic [`ZONE_W-1:0]             cancel_zone,
    output shelter_queue_pkg::slot_array_t entries,
    output logic                           queue_full
);

    logic [`SLOT_COUNT-1:0] valid_vec;
    logic [`SLOT_COUNT-1:0] write_vec;
    logic [`SLOT_COUNT-1:0] serve_vec;
    logic [`SLOT_COUNT-1:0] cancel_vec;
    logic [`SLOT_COUNT-1:0] clear_vec;

    always_comb begin
        for (int i = 0; i < `SLOT_COUNT; i++) begin
            valid_vec[i] = entries[i].valid;
        end
    end

    // ------------------------------------------------------------------------
    // Insert placement into the lowest empty slot
    // ------------------------------------------------------------------------
    always_comb begin
        logic taken;
        taken = 1'b0;
        for (int i = 0; i < `SLOT_COUNT; i++) begin
            write_vec[i] = insert && !valid_vec[i] && !taken;
            if (!valid_vec[i]) begin
                taken = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Serve decode and cancel match, merged into the per-slot clear
    // ------------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < `SLOT_COUNT; i++) begin
            serve_vec[i]  = serve && (selected_index == `INDEX_W'(i));
            cancel_vec[i] = cancel_en && valid_vec[i] && (entries[i].zone == cancel_zone);
        end
    end

    assign clear_vec = serve_vec | cancel_vec;

    // No free slot left, further inserts fall through
    assign queue_full = &valid_vec;

    // Slots
    for (genvar i = 0; i < `SLOT_COUNT; i++) begin : g_slot
        request_slot slot0 (
            .clk       (clk),
            .reset     (reset),
            .write     (write_vec[i]),
            .clear     (clear_vec[i]),
            .new_zone  (new_zone),
            .new_prio  (new_prio),
            .threshold (threshold),
            .entry     (entries[i])
        );

        // Full-queue insert must leave the held request alone
        a_full_insert_ignored : assert property (
            @(posedge clk) disable iff (reset)
            insert && queue_full && !serve && !cancel_en
            |=> entries[i].valid
                && entries[i].zone == $past(entries[i].zone)
                && entries[i].prio == $past(entries[i].prio)
        );
    end

    // Placement picks one slot at most
    a_single_write : assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(write_vec)
    );

endmodule

// File: rtl/shelter_queue.sv
// Shelter zone priority queue
`timescale 1ns/1ps
`include "shelter_queue_settings.svh"

module shelter_queue (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        insert,
    input  logic [`ZONE_W-1:0]          new_zone,
    input  logic [`PRIO_W-1:0]          new_prio,
    input  logic [`WAIT_W-1:0]          threshold,
    input  logic                        serve,
    input  logic                        cancel_en,
    input  logic [`ZONE_W-1:0]          cancel_zone,
    output shelter_queue_pkg::request_t selected,
    output logic                        selected_valid,
    output logic                        queue_full
);

    shelter_queue_pkg::slot_array_t entries;
    logic [`INDEX_W-1:0]            selected_index;

    // ------------------------------------------------------------------------
    // Slot state
    // ------------------------------------------------------------------------
    queue_storage storage0 (
        .clk            (clk),
        .reset          (reset),
        .insert         (insert),
        .new_zone       (new_zone),
        .new_prio       (new_prio),
        .threshold      (threshold),
        .serve          (serve),
        .selected_index (selected_index),
        .cancel_en      (cancel_en),
        .cancel_zone    (cancel_zone),
        .entries        (entries),
        .queue_full     (queue_full)
    );

    // ------------------------------------------------------------------------
    // Combinational pick of the head request
    // ------------------------------------------------------------------------
    selector_tree selector0 (
        .entries        (entries),
        .selected       (selected),
        .selected_index (selected_index)
    );

    assign selected_valid = selected.valid;

endmodule

// File: test/tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset held over the first three rising edges
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #10;
        reset = 1'b0;
    end

endmodule

// File: test/shelter_queue_tb.sv
// Shelter queue testbench
`timescale 1ns/1ps
`include "shelter_queue_settings.svh"

module shelter_queue_tb;

    localparam string STIM_FILE   = "test/shelter_queue_stimulus.txt";
    localparam int    FIELD_COUNT = 13;
    localparam int    MAX_ROWS    = 64;

    logic                        clk;
    logic                        reset;
    logic                        insert;
    logic [`ZONE_W-1:0]          new_zone;
    logic [`PRIO_W-1:0]          new_prio;
    logic [`WAIT_W-1:0]          threshold;
    logic                        serve;
    logic                        cancel_en;
    logic [`ZONE_W-1:0]          cancel_zone;
    shelter_queue_pkg::request_t selected;
    logic                        selected_valid;
    logic                        queue_full;

    logic [7:0] stim_mem [0:MAX_ROWS*FIELD_COUNT-1];
    // Row in which each zone was last accepted into the queue
    int         insert_row [0:(1<<`ZONE_W)-1];
    int         row_count;
    int         current_row;
    int         error_count;
    int         group_errors;
    int         group_count;
    int         cycle_count;
    int         cycle_limit;

    tb_clock_gen clock0 (
        .clk   (clk),
        .reset (reset)
    );

    shelter_queue dut0 (
        .clk            (clk),
        .reset          (reset),
        .insert         (insert),
        .new_zone       (new_zone),
        .new_prio       (new_prio),
        .threshold      (threshold),
        .serve          (serve),
        .cancel_en      (cancel_en),
        .cancel_zone    (cancel_zone),
        .selected       (selected),
        .selected_valid (selected_valid),
        .queue_full     (queue_full)
    );

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h (row %0d)",
                     name, actual, expected, current_row);
            error_count++;
            group_errors++;
        end
    endtask

    function automatic string group_name(input int group);
        case (group)
            1:       return "reset and empty queue";
            2:       return "priority order";
            3:       return "serve";
            4:       return "full queue";
            5:       return "cancel";
            6:       return "aging boost";
            default: return "unnamed";
        endcase
    endfunction

    task automatic load_stimulus(output bit ok);
        int fd;
        fd = $fopen(STIM_FILE, "r");
        ok = (fd != 0);
        if (ok) begin
            $fclose(fd);
            $readmemh(STIM_FILE, stim_mem);
            row_count = 0;
            while (row_count < MAX_ROWS &&
                   !$isunknown(stim_mem[row_count*FIELD_COUNT])) begin
                row_count++;
            end
        end
    endtask

    task automatic drive_idle();
        insert      = 1'b0;
        new_zone    = '0;
        new_prio    = '0;
        threshold   = '1;
        serve       = 1'b0;
        cancel_en   = 1'b0;
        cancel_zone = '0;
    endtask

    task automatic drive_row(input int row);
        int base;
        base        = row * FIELD_COUNT;
        insert      = stim_mem[base+1][0];
        new_zone    = stim_mem[base+2];
        new_prio    = stim_mem[base+3][`PRIO_W-1:0];
        threshold   = stim_mem[base+4];
        serve       = stim_mem[base+5][0];
        cancel_en   = stim_mem[base+6][0];
        cancel_zone = stim_mem[base+7];
    endtask

    task automatic report_group(input int group);
        if (group_errors == 0) begin
            $display("group %0d %s: pass", group, group_name(group));
        end else begin
            $display("group %0d %s: fail, %0d errors", group, group_name(group),
                     group_errors);
        end
        group_count++;
        group_errors = 0;
    endtask

    // Row outputs settle one clock after the row was driven
    task automatic check_row(input int row);
        int                 base;
        int                 group;
        bit                 was_full;
        logic [`WAIT_W-1:0] wait_expected;
        base        = row * FIELD_COUNT;
        group       = stim_mem[base];
        current_row = row;
        was_full    = 1'b0;
        if (row > 0) begin
            was_full = stim_mem[base-FIELD_COUNT+12][0];
        end
        // An accepted insert shows wait 0 here and ages by one per row
        if (stim_mem[base+1][0] && !was_full) begin
            insert_row[stim_mem[base+2]] = row;
        end
        check_value("selected.zone", selected.zone, stim_mem[base+8]);
        check_value("selected.prio", selected.prio, stim_mem[base+9]);
        check_value("selected.boost", selected.boost, stim_mem[base+10]);
        check_value("selected_valid", selected_valid, stim_mem[base+11]);
        check_value("queue_full", queue_full, stim_mem[base+12]);
        if (stim_mem[base+11][0]) begin
            wait_expected = `WAIT_W'(row - insert_row[stim_mem[base+8]]);
            check_value("selected.wait_time", selected.wait_time, wait_expected);
        end
        if (row == row_count - 1 || stim_mem[base+FIELD_COUNT] != group) begin
            report_group(group);
        end
    endtask

    task automatic run_rows();
        for (int k = 0; k <= row_count; k++) begin
            @(posedge clk);
            #10;
            if (k < row_count) begin
                drive_row(k);
            end else begin
                drive_idle();
            end
            // Just before the next rising edge
            #80;
            if (k > 0) begin
                check_row(k - 1);
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Timeout guard
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, stimulus did not finish", cycle_count);
            $display("Test FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        bit ok;
        drive_idle();
        row_count    = 0;
        current_row  = 0;
        error_count  = 0;
        group_errors = 0;
        group_count  = 0;
        cycle_count  = 0;
        cycle_limit  = 0;
        load_stimulus(ok);
        if (!ok) begin
            $display("Could not open stimulus file %s", STIM_FILE);
            $display("Test FAILED");
            $finish;
        end else begin
            cycle_limit = 2 * row_count + 20;
            if (row_count == 0) begin
                $display("No stimulus rows found in %s", STIM_FILE);
                error_count++;
            end
            wait (reset == 1'b0);
            run_rows();
            $display("Rows %0d, groups %0d, errors %0d", row_count, group_count,
                     error_count);
            if (error_count == 0) begin
                $display("Test OK");
            end else begin
                $display("Test FAILED");
            end
            $finish;
        end
    end

endmodule

// File: shelter_queue.f
+incdir+include
rtl/shelter_queue_pkg.sv
rtl/request_slot.sv
rtl/pair_arbiter.sv
rtl/selector_tree.sv
rtl/queue_storage.sv
rtl/shelter_queue.sv
test/tb_clock_gen.sv
test/shelter_queue_tb.sv

// File: test/shelter_queue_stimulus.txt
// grp ins zone prio thr serve cancel czone, then outputs one cycle later:
// zone prio boost valid full. All hex, one row per clock cycle
// Reset and empty queue
1 0 00 0 ff 0 0 00  00 0 0 0 0
1 0 00 0 ff 0 0 00  00 0 0 0 0
// Priority order
2 1 11 1 ff 0 0 00  11 1 0 1 0
2 1 12 3 ff 0 0 00  12 3 0 1 0
2 1 13 1 ff 0 0 00  12 3 0 1 0
// Serve, equal priorities fall back to the longer wait
3 0 00 0 ff 1 0 00  11 1 0 1 0
3 0 00 0 ff 1 0 00  13 1 0 1 0
3 0 00 0 ff 1 0 00  00 0 0 0 0
3 0 00 0 ff 1 0 00  00 0 0 0 0
// Full queue, fifth insert dropped
4 1 21 2 ff 0 0 00  21 2 0 1 0
4 1 22 0 ff 0 0 00  21 2 0 1 0
4 1 23 1 ff 0 0 00  21 2 0 1 0
4 1 24 3 ff 0 0 00  24 3 0 1 1
4 1 25 3 ff 0 0 00  24 3 0 1 1
4 0 00 0 ff 1 0 00  21 2 0 1 0
4 0 00 0 ff 1 0 00  23 1 0 1 0
4 0 00 0 ff 1 0 00  22 0 0 1 0
4 0 00 0 ff 1 0 00  00 0 0 0 0
// Cancel, then cancel of an absent zone
5 1 31 1 ff 0 0 00  31 1 0 1 0
5 1 32 2 ff 0 0 00  32 2 0 1 0
5 1 31 0 ff 0 0 00  32 2 0 1 0
5 0 00 0 ff 0 1 31  32 2 0 1 0
5 0 00 0 ff 0 1 77  32 2 0 1 0
5 0 00 0 ff 0 1 32  00 0 0 0 0
// Aging boost with threshold 3
6 1 41 0 03 0 0 00  41 0 0 1 0
6 0 00 0 03 0 0 00  41 0 0 1 0
6 0 00 0 03 0 0 00  41 0 0 1 0
6 1 42 3 03 0 0 00  42 3 0 1 0
6 0 00 0 03 0 0 00  41 0 1 1 0
6 0 00 0 03 0 0 00  41 0 1 1 0
6 0 00 0 03 1 0 00  42 3 0 1 0
6 0 00 0 03 0 0 00  42 3 1 1 0
6 0 00 0 03 0 1 42  00 0 0 0 0
